// File: files.f
+incdir+.
rv_decode_pkg.sv
op_decoder.sv
imm_gen.sv
reg_lock_queue.sv
issue_register.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f files.f --top-module tb_decode_stage -o tb_decode_stage_sim
then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_decode_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1

// File: tb_decode_stage.sv
////////////////////////////////////////
// Decode stage testbench: stimulus, bank
// model, reference model and scoreboard
////////////////////////////////////////
`include "rv_decode_consts.svh"

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] lcg_seed = 32'hbc43_de88;
    localparam int directed_count = 55;
    localparam int random_count = 300;
    localparam int wait_limit = 100;

    localparam logic [31:0] directed_words [directed_count] = '{
        32'h12345537, 32'hfffff197, 32'hffdff0ef, 32'h00008067,              // U, J, JALR
        32'h00208463, 32'hfe4198e3, 32'h0020c463, 32'h0020d463, 32'h0020e463,
        32'h0020f463,                                                         // Branches
        32'hff830283, 32'hff831283, 32'hff832283, 32'hff834283, 32'hff835283, // Loads
        32'h00740623, 32'h00741623, 32'h00742623, 32'hfe912e23,              // Stores
        32'hfff60593, 32'hfff62593, 32'hfff63593, 32'hfff64593, 32'hfff66593,
        32'hfff67593, 32'h00361593, 32'h00365593, 32'h40365593,              // OP-IMM
        32'h00f706b3, 32'h40f706b3, 32'h00f716b3, 32'h00f726b3, 32'h00f736b3,
        32'h00f746b3, 32'h00f756b3, 32'h40f756b3, 32'h00f766b3, 32'h00f776b3, // OP
        32'h0ff0000f,                                                         // FENCE
        32'h00000073, 32'h00100073, 32'h30529073, 32'h30200073, 32'h10500073, // System
        32'h02f706b3, 32'hff833283, 32'h0020a463, 32'h40361593, 32'hffffffff,
        32'h00700293, 32'h00128333, 32'h00000013, 32'h000003b3,              // RAW, x0
        32'h00742623, 32'hff832283                                            // Store, load
    };

    localparam logic [6:0] kept_opcodes [10] = '{
        `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
        `OPC_LOAD, `OPC_STORE, `OPC_OPIMM, `OPC_OP, `OPC_FENCE
    };

    logic                      clk;
    logic                      reset;
    rv_decode_pkg::fetch_pkt_t fetch;
    logic                      fetch_valid;
    logic                      fetch_ready;
    rv_decode_pkg::reg_read_t  reg_read;
    rv_decode_pkg::reg_data_t  reg_data;
    rv_decode_pkg::issue_pkt_t issue;
    logic                      issue_valid;
    logic                      issue_ready;
    logic [4:0]                wb_rd;

    rv_decode_pkg::issue_pkt_t scoreboard [$];
    rv_decode_pkg::issue_pkt_t expected;
    rv_decode_pkg::op_e        op_now;
    logic [4:0]                lock_rd [2];
    logic                      lock_store [2];
    logic                      advance;
    logic                      accept;
    logic                      raw_block;
    logic                      mem_block;
    logic [31:0]               word_now;
    logic [31:0]               ready_state;
    logic [31:0]               next_pc;
    logic [2:0]                next_tag;
    int                        out_count;
    int                        raw_stalls;
    int                        mem_stalls;
    string                     test_name;

    tb_clock_gen clock_gen_inst (
        .clk_o   (clk),
        .reset_o (reset)
    );

    decode_stage decode_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .fetch_i       (fetch),
        .fetch_valid_i (fetch_valid),
        .fetch_ready_o (fetch_ready),
        .reg_read_o    (reg_read),
        .reg_data_i    (reg_data),
        .issue_o       (issue),
        .issue_valid_o (issue_valid),
        .issue_ready_i (issue_ready),
        .wb_rd_o       (wb_rd)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Register bank model with a distinct value per address
    function automatic logic [31:0] bank_value(input logic [4:0] addr);
        bank_value = (addr == 5'd0) ? 32'h0 : {8'hb5, 3'b000, addr, 8'h3c, 3'b000, addr};
    endfunction

    assign reg_data.rs1_data = bank_value(reg_read.rs1);
    assign reg_data.rs2_data = bank_value(reg_read.rs2);

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic rv_decode_pkg::op_e alu_op(input logic [2:0] f3);
        case (f3)
            3'd0:    alu_op = rv_decode_pkg::ADD;
            3'd1:    alu_op = rv_decode_pkg::SLL;
            3'd2:    alu_op = rv_decode_pkg::SLT;
            3'd3:    alu_op = rv_decode_pkg::SLTU;
            3'd4:    alu_op = rv_decode_pkg::XOR;
            3'd5:    alu_op = rv_decode_pkg::SRL;
            3'd6:    alu_op = rv_decode_pkg::OR;
            default: alu_op = rv_decode_pkg::AND;
        endcase
    endfunction

    function automatic rv_decode_pkg::op_e ref_op(input logic [31:0] w);
        logic [2:0]         f3;
        logic [6:0]         f7;
        rv_decode_pkg::op_e op;
        f3 = w[14:12];
        f7 = w[31:25];
        op = rv_decode_pkg::INVALID;
        case (w[6:0])
            `OPC_LUI:   op = rv_decode_pkg::LUI;
            `OPC_AUIPC: op = rv_decode_pkg::ADD;
            `OPC_JAL:   op = rv_decode_pkg::JAL;
            `OPC_JALR:  if (f3 == 3'd0) op = rv_decode_pkg::JALR;
            `OPC_FENCE: if (f3 == 3'd0) op = rv_decode_pkg::NOP;
            `OPC_BRANCH: begin
                case (f3)
                    3'd0: op = rv_decode_pkg::BEQ;
                    3'd1: op = rv_decode_pkg::BNE;
                    3'd4: op = rv_decode_pkg::BLT;
                    3'd5: op = rv_decode_pkg::BGE;
                    3'd6: op = rv_decode_pkg::BLTU;
                    3'd7: op = rv_decode_pkg::BGEU;
                    default: op = rv_decode_pkg::INVALID;
                endcase
            end
            `OPC_LOAD: begin
                case (f3)
                    3'd0: op = rv_decode_pkg::LB;
                    3'd1: op = rv_decode_pkg::LH;
                    3'd2: op = rv_decode_pkg::LW;
                    3'd4: op = rv_decode_pkg::LBU;
                    3'd5: op = rv_decode_pkg::LHU;
                    default: op = rv_decode_pkg::INVALID;
                endcase
            end
            `OPC_STORE: begin
                if (f3 == 3'd0) op = rv_decode_pkg::SB;
                else if (f3 == 3'd1) op = rv_decode_pkg::SH;
                else if (f3 == 3'd2) op = rv_decode_pkg::SW;
            end
            `OPC_OPIMM: begin                            // Only shifts look at funct7
                if (f3 != 3'd1 && f3 != 3'd5) op = alu_op(f3);
                else if (f7 == `F7_BASE) op = alu_op(f3);
                else if (f7 == `F7_ALT && f3 == 3'd5) op = rv_decode_pkg::SRA;
            end
            `OPC_OP: begin
                if (f7 == `F7_BASE) op = alu_op(f3);
                else if (f7 == `F7_ALT && f3 == 3'd0) op = rv_decode_pkg::SUB;
                else if (f7 == `F7_ALT && f3 == 3'd5) op = rv_decode_pkg::SRA;
            end
            default: op = rv_decode_pkg::INVALID;
        endcase
        ref_op = op;
    endfunction

    function automatic rv_decode_pkg::format_e ref_format(input logic [6:0] opcode);
        case (opcode)
            `OPC_OPIMM, `OPC_JALR, `OPC_LOAD: ref_format = rv_decode_pkg::I_TYPE;
            `OPC_STORE:                       ref_format = rv_decode_pkg::S_TYPE;
            `OPC_BRANCH:                      ref_format = rv_decode_pkg::B_TYPE;
            `OPC_LUI, `OPC_AUIPC:             ref_format = rv_decode_pkg::U_TYPE;
            `OPC_JAL:                         ref_format = rv_decode_pkg::J_TYPE;
            default:                          ref_format = rv_decode_pkg::R_TYPE;
        endcase
    endfunction

    function automatic rv_decode_pkg::issue_pkt_t expected_issue(
        input rv_decode_pkg::fetch_pkt_t f
    );
        logic [31:0]               w;
        logic [31:0]               imm;
        logic [31:0]               rs1_val;
        logic [31:0]               rs2_val;
        rv_decode_pkg::format_e    fmt;
        rv_decode_pkg::issue_pkt_t e;
        w = f.instr;
        fmt = ref_format(w[6:0]);
        rs1_val = bank_value(w[19:15]);
        rs2_val = bank_value(w[24:20]);
        case (fmt)
            rv_decode_pkg::I_TYPE: imm = {{20{w[31]}}, w[31:20]};
            rv_decode_pkg::S_TYPE: imm = {{20{w[31]}}, w[31:25], w[11:7]};
            rv_decode_pkg::B_TYPE: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            rv_decode_pkg::U_TYPE: imm = {w[31:12], 12'h000};
            rv_decode_pkg::J_TYPE: imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:               imm = 32'h0;
        endcase
        e.op = ref_op(w);
        e.operand1 = (fmt == rv_decode_pkg::U_TYPE || fmt == rv_decode_pkg::J_TYPE)
                     ? f.pc : rs1_val;
        e.operand2 = (fmt == rv_decode_pkg::R_TYPE || fmt == rv_decode_pkg::B_TYPE)
                     ? rs2_val : imm;
        e.operand3 = (fmt == rv_decode_pkg::S_TYPE) ? rs2_val : imm;
        e.pc = f.pc;
        e.instr = f.instr;
        e.tag = f.tag;
        e.rd = w[11:7];
        e.exception = (e.op == rv_decode_pkg::INVALID);
        expected_issue = e;
    endfunction

    function automatic logic is_memory(input rv_decode_pkg::op_e op);
        is_memory = op inside {rv_decode_pkg::LB, rv_decode_pkg::LH, rv_decode_pkg::LW,
                               rv_decode_pkg::LBU, rv_decode_pkg::LHU, rv_decode_pkg::SB,
                               rv_decode_pkg::SH, rv_decode_pkg::SW};
    endfunction

    function automatic logic is_store(input rv_decode_pkg::op_e op);
        is_store = op inside {rv_decode_pkg::SB, rv_decode_pkg::SH, rv_decode_pkg::SW};
    endfunction

    ////////////////////////////////////////
    // Failure reporting and checking
    ////////////////////////////////////////
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [255:0] exp_val,
                               input logic [255:0] act_val);
        if (exp_val !== act_val)
            report_failure($sformatf("mismatch in %s, %s: expected %0h, actual %0h",
                                     test_name, name, exp_val, act_val));
    endtask

    // Samples mid-cycle where every value holds until the next rising edge
    always @(negedge clk) begin
        if (reset) begin
            lock_rd[0] = 5'd0;
            lock_rd[1] = 5'd0;
            lock_store[0] = 1'b0;
            lock_store[1] = 1'b0;
            scoreboard.delete();
        end else begin
            word_now = fetch.instr;
            op_now = ref_op(word_now);
            advance = issue_ready || !issue_valid;
            raw_block = (lock_rd[0] != 5'd0) &&
                        (lock_rd[0] == word_now[19:15] || lock_rd[0] == word_now[24:20]);
            mem_block = (lock_store[0] || lock_store[1]) && is_memory(op_now);
            check_value("fetch ready", 256'(advance && !raw_block && !mem_block),
                        256'(fetch_ready));
            check_value("writeback rd", 256'(lock_rd[1]), 256'(wb_rd));
            check_value("issue valid", 256'(scoreboard.size() != 0), 256'(issue_valid));
            if (fetch_valid && raw_block)
                raw_stalls++;
            if (fetch_valid && mem_block)
                mem_stalls++;
            if (issue_valid && issue_ready) begin
                expected = scoreboard.pop_front();
                check_value("issue packet", 256'(expected), 256'(issue));
                out_count++;
            end
            accept = fetch_valid && fetch_ready;
            if (accept)
                scoreboard.push_back(expected_issue(fetch));
            if (advance) begin                          // Lock queue shifts at the next edge
                lock_rd[1] = lock_rd[0];
                lock_store[1] = lock_store[0];
                lock_rd[0] = accept ? word_now[11:7] : 5'd0;
                lock_store[0] = accept && is_store(op_now);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        ready_state = lcg_next(lcg_seed);
        issue_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            ready_state = lcg_next(ready_state);
            issue_ready = (ready_state[31:30] != 2'b00);   // Low about a quarter of cycles
        end
    end

    task automatic send_word(input logic [31:0] word);
        int waited;
        waited = 0;
        fetch.instr = word;
        fetch.pc = next_pc;
        fetch.tag = next_tag;
        fetch_valid = 1'b1;
        @(negedge clk);
        while (!fetch_ready) begin
            waited++;
            if (waited > wait_limit)
                report_failure("a fetched word was never accepted by the decode stage");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        next_pc = next_pc + 32'd4;
        next_tag = next_tag + 3'd1;
    endtask

    initial begin
        logic [31:0] gen_state;
        logic [31:0] word;
        int          waited;
        int          sel;
        fetch = '0;
        fetch_valid = 1'b0;
        next_pc = 32'h0000_1000;
        next_tag = 3'd0;
        out_count = 0;
        raw_stalls = 0;
        mem_stalls = 0;
        test_name = "reset";
        waited = 0;
        @(posedge clk);
        while (reset) begin
            waited++;
            if (waited > 20)
                report_failure("reset was never released");
            @(posedge clk);
        end
        #1;
        test_name = "directed";
        for (int i = 0; i < directed_count; i++)
            send_word(directed_words[i]);

        test_name = "random";
        gen_state = lcg_seed;
        for (int i = 0; i < random_count; i++) begin
            gen_state = lcg_next(gen_state);
            word = gen_state;
            gen_state = lcg_next(gen_state);
            sel = int'(gen_state[27:24]) % 10;
            if (gen_state[31:29] != 3'd0)
                word[6:0] = kept_opcodes[sel];          // Mostly kept groups
            if (gen_state[20])
                word[31:25] = {1'b0, gen_state[21], 5'b00000};
            if (gen_state[7:6] == 2'b00) begin
                @(posedge clk);                         // Idle cycle between words
                #1;
            end
            send_word(word);
        end

        test_name = "drain";
        waited = 0;
        @(posedge clk);
        while (scoreboard.size() != 0) begin
            waited++;
            if (waited > wait_limit)
                report_failure("issued words did not drain from the decode stage");
            @(posedge clk);
        end
        check_value("transfer count", 256'(directed_count + random_count), 256'(out_count));
        check_value("raw stall seen", 256'(1), 256'(raw_stalls != 0));
        check_value("memory stall seen", 256'(1), 256'(mem_stalls != 0));
        $display("Regression passed");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
////////////////////////////////////////
// Testbench clock and synchronous reset
////////////////////////////////////////

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;               // 20 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clk_o);
        #1 reset_o = 1'b0;                        // Released just after the 8th edge
    end

endmodule

// File: decode_stage.sv
////////////////////////////////////////
// Decode stage top: decoder, immediate,
// lock queue and issue register
////////////////////////////////////////
`include "rv_decode_consts.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  rv_decode_pkg::fetch_pkt_t fetch_i,
    input  logic                      fetch_valid_i,
    output logic                      fetch_ready_o,
    output rv_decode_pkg::reg_read_t  reg_read_o,
    input  rv_decode_pkg::reg_data_t  reg_data_i,
    output rv_decode_pkg::issue_pkt_t issue_o,
    output logic                      issue_valid_o,
    input  logic                      issue_ready_i,
    output logic [`REG_ADDR_W-1:0]    wb_rd_o
);

    rv_decode_pkg::op_e     op;
    rv_decode_pkg::format_e format;
    logic                   invalid;
    logic [`XLEN-1:0]       imm;
    logic                   hazard;
    logic                   advance;
    logic                   accept;

    assign reg_read_o.rs1 = fetch_i.instr.r.rs1;     // Bank answers same cycle
    assign reg_read_o.rs2 = fetch_i.instr.r.rs2;

    assign advance       = issue_ready_i | ~issue_valid_o;
    assign fetch_ready_o = advance & ~hazard;
    assign accept        = fetch_valid_i & fetch_ready_o;

    op_decoder op_decoder_inst (
        .instr_i   (fetch_i.instr),
        .op_o      (op),
        .format_o  (format),
        .invalid_o (invalid)
    );

    imm_gen imm_gen_inst (
        .instr_i  (fetch_i.instr),
        .format_i (format),
        .imm_o    (imm)
    );

    reg_lock_queue reg_lock_queue_inst (
        .clk      (clk),
        .reset    (reset),
        .shift_i  (advance),
        .accept_i (accept),
        .rd_i     (fetch_i.instr.r.rd),
        .op_i     (op),
        .rs_i     (reg_read_o),
        .hazard_o (hazard),
        .wb_rd_o  (wb_rd_o)
    );

    issue_register issue_register_inst (
        .clk           (clk),
        .reset         (reset),
        .advance_i     (advance),
        .load_i        (accept),
        .fetch_i       (fetch_i),
        .reg_data_i    (reg_data_i),
        .op_i          (op),
        .format_i      (format),
        .imm_i         (imm),
        .invalid_i     (invalid),
        .issue_o       (issue_o),
        .issue_valid_o (issue_valid_o)
    );

endmodule

// File: issue_register.sv
////////////////////////////////////////
// Operand select and stage output register
////////////////////////////////////////
`include "rv_decode_consts.svh"

module issue_register (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     advance_i,
    input  logic                     load_i,
    input  rv_decode_pkg::fetch_pkt_t fetch_i,
    input  rv_decode_pkg::reg_data_t reg_data_i,
    input  rv_decode_pkg::op_e       op_i,
    input  rv_decode_pkg::format_e   format_i,
    input  logic [`XLEN-1:0]         imm_i,
    input  logic                     invalid_i,
    output rv_decode_pkg::issue_pkt_t issue_o,
    output logic                     issue_valid_o
);

    logic [`XLEN-1:0] operand1;
    logic [`XLEN-1:0] operand2;
    logic [`XLEN-1:0] operand3;

    ////////////////////////////////////////
    // Operand selection by format
    ////////////////////////////////////////
    always_comb begin
        operand1 = (format_i == rv_decode_pkg::U_TYPE || format_i == rv_decode_pkg::J_TYPE)
                   ? fetch_i.pc : reg_data_i.rs1_data;
        operand2 = (format_i == rv_decode_pkg::R_TYPE || format_i == rv_decode_pkg::B_TYPE)
                   ? reg_data_i.rs2_data : imm_i;
        operand3 = (format_i == rv_decode_pkg::S_TYPE)
                   ? reg_data_i.rs2_data : imm_i;   // Store data rides here
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            issue_o.op        <= op_i;
            issue_o.operand1  <= operand1;
            issue_o.operand2  <= operand2;
            issue_o.operand3  <= operand3;
            issue_o.pc        <= fetch_i.pc;
            issue_o.instr     <= fetch_i.instr;
            issue_o.tag       <= fetch_i.tag;
            issue_o.rd        <= fetch_i.instr.r.rd;
            issue_o.exception <= invalid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid_o <= 1'b0;
        end else if (advance_i) begin
            issue_valid_o <= load_i;                 // Bubble when nothing accepted
        end
    end

endmodule

// File: reg_lock_queue.sv
////////////////////////////////////////
// Two-entry register lock queue with
// RAW and store-to-memory hazard detection
////////////////////////////////////////
`include "rv_decode_consts.svh"

module reg_lock_queue (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          shift_i,
    input  logic                          accept_i,
    input  logic [`REG_ADDR_W-1:0]        rd_i,
    input  rv_decode_pkg::op_e            op_i,
    input  rv_decode_pkg::reg_read_t      rs_i,
    output logic                          hazard_o,
    output logic [`REG_ADDR_W-1:0]        wb_rd_o
);

    logic [`REG_ADDR_W-1:0] lock_rd [2];
    logic                   lock_store [2];
    logic                   is_store;
    logic                   mem_hazard;
    logic                   raw_hazard;

    assign is_store = op_i inside {rv_decode_pkg::SB, rv_decode_pkg::SH, rv_decode_pkg::SW};

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_rd[0]    <= '0;
            lock_rd[1]    <= '0;
            lock_store[0] <= 1'b0;
            lock_store[1] <= 1'b0;
        end else if (shift_i) begin
            lock_rd[0]    <= accept_i ? rd_i : '0;     // Bubble enters as zeros
            lock_store[0] <= accept_i & is_store;
            lock_rd[1]    <= lock_rd[0];
            lock_store[1] <= lock_store[0];
        end
    end

    assign mem_hazard = (lock_store[0] | lock_store[1]) &&
                        (rv_decode_pkg::exec_unit_e'(op_i[5:3]) == rv_decode_pkg::MEMORY);
    assign raw_hazard = (lock_rd[0] != '0) &&
                        ((lock_rd[0] == rs_i.rs1) || (lock_rd[0] == rs_i.rs2));

    assign hazard_o = mem_hazard | raw_hazard;
    assign wb_rd_o  = lock_rd[1];                    // Register being written back

endmodule

// File: imm_gen.sv
////////////////////////////////////////
// Sign-extended immediate generator
////////////////////////////////////////
`include "rv_decode_consts.svh"

module imm_gen (
    input  rv_decode_pkg::rv_instr_u instr_i,
    input  rv_decode_pkg::format_e   format_i,
    output logic [`XLEN-1:0]         imm_o
);

    logic [`XLEN-1:0] word;
    logic             sign;

    assign word = instr_i;
    assign sign = word[31];

    always_comb begin
        case (format_i)
            rv_decode_pkg::I_TYPE:
                imm_o = {{20{sign}}, instr_i.i.imm12};
            rv_decode_pkg::S_TYPE:
                imm_o = {{20{sign}}, instr_i.r.funct7, instr_i.r.rd};   // Split field
            rv_decode_pkg::B_TYPE:
                imm_o = {{20{sign}}, word[7], word[30:25], word[11:8], 1'b0};
            rv_decode_pkg::U_TYPE:
                imm_o = {word[31:12], 12'b0};
            rv_decode_pkg::J_TYPE:
                imm_o = {{12{sign}}, word[19:12], word[20], word[30:21], 1'b0};
            default:
                imm_o = '0;                          // R has no immediate
        endcase
    end

endmodule

// File: op_decoder.sv
////////////////////////////////////////
// Operation and format decoder for RV32I
////////////////////////////////////////
`include "rv_decode_consts.svh"

module op_decoder (
    input  rv_decode_pkg::rv_instr_u instr_i,
    output rv_decode_pkg::op_e       op_o,
    output rv_decode_pkg::format_e   format_o,
    output logic                     invalid_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    ////////////////////////////////////////
    // Operation
    ////////////////////////////////////////
    always_comb begin
        op_o = rv_decode_pkg::INVALID;               // Anything not matched below
        case (opcode)
            `OPC_LUI:   op_o = rv_decode_pkg::LUI;
            `OPC_AUIPC: op_o = rv_decode_pkg::ADD;   // pc + upper immediate
            `OPC_JAL:   op_o = rv_decode_pkg::JAL;
            `OPC_JALR: begin
                if (funct3 == `F3_ZERO)
                    op_o = rv_decode_pkg::JALR;
            end
            `OPC_BRANCH: begin
                case (funct3)
                    `F3_ZERO:  op_o = rv_decode_pkg::BEQ;
                    `F3_ONE:   op_o = rv_decode_pkg::BNE;
                    `F3_FOUR:  op_o = rv_decode_pkg::BLT;
                    `F3_FIVE:  op_o = rv_decode_pkg::BGE;
                    `F3_SIX:   op_o = rv_decode_pkg::BLTU;
                    `F3_SEVEN: op_o = rv_decode_pkg::BGEU;
                    default:   op_o = rv_decode_pkg::INVALID;
                endcase
            end
            `OPC_LOAD: begin
                case (funct3)
                    `F3_ZERO: op_o = rv_decode_pkg::LB;
                    `F3_ONE:  op_o = rv_decode_pkg::LH;
                    `F3_TWO:  op_o = rv_decode_pkg::LW;
                    `F3_FOUR: op_o = rv_decode_pkg::LBU;
                    `F3_FIVE: op_o = rv_decode_pkg::LHU;
                    default:  op_o = rv_decode_pkg::INVALID;
                endcase
            end
            `OPC_STORE: begin
                case (funct3)
                    `F3_ZERO: op_o = rv_decode_pkg::SB;
                    `F3_ONE:  op_o = rv_decode_pkg::SH;
                    `F3_TWO:  op_o = rv_decode_pkg::SW;
                    default:  op_o = rv_decode_pkg::INVALID;
                endcase
            end
            `OPC_OPIMM: begin
                case (funct3)
                    `F3_ZERO:  op_o = rv_decode_pkg::ADD;
                    `F3_TWO:   op_o = rv_decode_pkg::SLT;
                    `F3_SLTU:  op_o = rv_decode_pkg::SLTU;
                    `F3_FOUR:  op_o = rv_decode_pkg::XOR;
                    `F3_SIX:   op_o = rv_decode_pkg::OR;
                    `F3_SEVEN: op_o = rv_decode_pkg::AND;
                    `F3_ONE: begin
                        if (funct7 == `F7_BASE)
                            op_o = rv_decode_pkg::SLL;
                    end
                    default: begin                   // SRLI or SRAI
                        if (funct7 == `F7_BASE)
                            op_o = rv_decode_pkg::SRL;
                        else if (funct7 == `F7_ALT)
                            op_o = rv_decode_pkg::SRA;
                    end
                endcase
            end
            `OPC_OP: begin
                if (funct7 == `F7_BASE) begin
                    case (funct3)
                        `F3_ZERO:  op_o = rv_decode_pkg::ADD;
                        `F3_ONE:   op_o = rv_decode_pkg::SLL;
                        `F3_TWO:   op_o = rv_decode_pkg::SLT;
                        `F3_SLTU:  op_o = rv_decode_pkg::SLTU;
                        `F3_FOUR:  op_o = rv_decode_pkg::XOR;
                        `F3_FIVE:  op_o = rv_decode_pkg::SRL;
                        `F3_SIX:   op_o = rv_decode_pkg::OR;
                        default:   op_o = rv_decode_pkg::AND;
                    endcase
                end else if (funct7 == `F7_ALT) begin
                    if (funct3 == `F3_ZERO)
                        op_o = rv_decode_pkg::SUB;
                    else if (funct3 == `F3_FIVE)
                        op_o = rv_decode_pkg::SRA;
                end
            end
            `OPC_FENCE: begin
                if (funct3 == `F3_ZERO)
                    op_o = rv_decode_pkg::NOP;       // No ordering needed in-order
            end
            default: op_o = rv_decode_pkg::INVALID;
        endcase
    end

    assign invalid_o = (op_o == rv_decode_pkg::INVALID);

    ////////////////////////////////////////
    // Format from opcode alone
    ////////////////////////////////////////
    always_comb begin
        case (opcode)
            `OPC_OPIMM, `OPC_JALR, `OPC_LOAD: format_o = rv_decode_pkg::I_TYPE;
            `OPC_STORE:                       format_o = rv_decode_pkg::S_TYPE;
            `OPC_BRANCH:                      format_o = rv_decode_pkg::B_TYPE;
            `OPC_LUI, `OPC_AUIPC:             format_o = rv_decode_pkg::U_TYPE;
            `OPC_JAL:                         format_o = rv_decode_pkg::J_TYPE;
            default:                          format_o = rv_decode_pkg::R_TYPE;
        endcase
    end

endmodule

// File: rv_decode_pkg.sv
////////////////////////////////////////
// Decode types: unit, operation and format
// enums, instruction union, stream structs
////////////////////////////////////////
`include "rv_decode_consts.svh"

package rv_decode_pkg;

    // Shifts get their own unit code since the ALU group fills all eight slots
    typedef enum logic [2:0] {
        ALU    = 3'd0,
        SHIFT  = 3'd1,
        BRANCH = 3'd2,
        MEMORY = 3'd3,
        NONE   = 3'd7
    } exec_unit_e;

    // Upper octal digit is the execution unit
    typedef enum logic [5:0] {
        LUI  = 6'o00, ADD  = 6'o01, SUB  = 6'o02, SLT  = 6'o03,
        SLTU = 6'o04, XOR  = 6'o05, OR   = 6'o06, AND  = 6'o07,
        SLL  = 6'o10, SRL  = 6'o11, SRA  = 6'o12,
        JAL  = 6'o20, JALR = 6'o21, BEQ  = 6'o22, BNE  = 6'o23,
        BLT  = 6'o24, BGE  = 6'o25, BLTU = 6'o26, BGEU = 6'o27,
        LB   = 6'o30, LH   = 6'o31, LW   = 6'o32, LBU  = 6'o33,
        LHU  = 6'o34, SB   = 6'o35, SH   = 6'o36, SW   = 6'o37,
        NOP  = 6'o70, INVALID = 6'o77
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } rv_instr_u;

    typedef struct packed {
        rv_instr_u          instr;
        logic [`XLEN-1:0]   pc;
        logic [`TAG_W-1:0]  tag;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
    } reg_read_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
    } reg_data_t;

    typedef struct packed {
        op_e                    op;
        logic [`XLEN-1:0]       operand1;
        logic [`XLEN-1:0]       operand2;
        logic [`XLEN-1:0]       operand3;
        logic [`XLEN-1:0]       pc;
        rv_instr_u              instr;
        logic [`TAG_W-1:0]      tag;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   exception;
    } issue_pkt_t;

endpackage

// File: rv_decode_consts.svh
////////////////////////////////////////
// RV32I decode constants: widths, opcodes
// and funct codes of the kept instruction groups
////////////////////////////////////////
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

`define XLEN          32
`define REG_ADDR_W    5
`define TAG_W         3
`define REG_COUNT     32

`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OPIMM     7'b0010011
`define OPC_OP        7'b0110011
`define OPC_FENCE     7'b0001111

`define F7_BASE       7'b0000000
`define F7_ALT        7'b0100000

`define F3_ZERO       3'b000    // ADD/SUB, BEQ, LB/SB, JALR, FENCE
`define F3_ONE        3'b001    // SLL, BNE, LH/SH
`define F3_TWO        3'b010    // SLT, LW/SW
`define F3_SLTU       3'b011
`define F3_FOUR       3'b100    // XOR, BLT, LBU
`define F3_FIVE       3'b101    // SRL/SRA, BGE, LHU
`define F3_SIX        3'b110    // OR, BLTU
`define F3_SEVEN      3'b111    // AND, BGEU

`endif
